//--- source/tinker_pkg.sv
package tinker_pkg;

    localparam int XLEN    = 64;  // datapath width
    localparam int INSTR_W = 32;  // fetch word
    localparam int ADDR_W  = 32;  // byte address
    localparam int REG_AW  = 5;   // 32 registers
    localparam int LIT_W   = 12;
    localparam int PC_STEP = 4;   // no branches, pc only steps or holds

    // field lsb positions, literal starts at bit 0
    localparam int OP_LSB = 27;
    localparam int RD_LSB = 22;
    localparam int RS_LSB = 17;
    localparam int RT_LSB = 12;

    // mov r0 r0, opcode 0x11 in bits 31..27
    localparam logic [INSTR_W-1:0] NOP_INSTR = 32'h8800_0000;

    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_HALT   = 5'h0F,
        OP_LOAD   = 5'h10,  // mov rd (rs)(L)
        OP_MOV    = 5'h11,  // mov rd rs
        OP_MOVL   = 5'h12,  // mov rd L, low 12 bits only
        OP_STORE  = 5'h13,  // mov (rd)(L) rs
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1A,
        OP_SUBI   = 5'h1B
    } opcode_t;

    // operand source, newest wins
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_t;

endpackage

//--- source/unified_memory.sv
`timescale 1ns/1ps

module unified_memory #(
    parameter int MEM_BYTES = 512 * 1024
) (
    input  logic                           clk,
    input  logic                           prog_we,     // loader strobe, only during reset
    input  logic [tinker_pkg::ADDR_W-1:0]  prog_addr,
    input  logic [tinker_pkg::INSTR_W-1:0] prog_data,
    input  logic [tinker_pkg::ADDR_W-1:0]  fetch_addr,
    output logic [tinker_pkg::INSTR_W-1:0] fetch_instr,
    input  logic [tinker_pkg::ADDR_W-1:0]  data_addr,   // shared by load and store
    output logic [tinker_pkg::XLEN-1:0]    data_rdata,
    input  logic                           store_we,
    input  logic [tinker_pkg::XLEN-1:0]    store_data
);
    localparam int FETCH_BYTES = tinker_pkg::INSTR_W / 8;
    localparam int DATA_BYTES  = tinker_pkg::XLEN / 8;

    logic [7:0] mem_bytes [MEM_BYTES];

    // little endian, lowest address is the low byte
    always_comb begin
        for (int i = 0; i < FETCH_BYTES; i++)
            fetch_instr[8*i +: 8] = mem_bytes[fetch_addr + i];
        for (int i = 0; i < DATA_BYTES; i++)
            data_rdata[8*i +: 8] = mem_bytes[data_addr + i];
    end

    // program load beats a store
    always_ff @(posedge clk) begin
        if (prog_we) begin
            for (int i = 0; i < FETCH_BYTES; i++)
                mem_bytes[prog_addr + i] <= prog_data[8*i +: 8];
        end else if (store_we) begin
            for (int i = 0; i < DATA_BYTES; i++)
                mem_bytes[data_addr + i] <= store_data[8*i +: 8];
        end
    end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter logic [tinker_pkg::XLEN-1:0] STACK_TOP = 64'h8_0000
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [tinker_pkg::REG_AW-1:0] rd,
    input  logic [tinker_pkg::REG_AW-1:0] rs,
    input  logic [tinker_pkg::REG_AW-1:0] rt,
    output logic [tinker_pkg::XLEN-1:0]   rd_val,
    output logic [tinker_pkg::XLEN-1:0]   rs_val,
    output logic [tinker_pkg::XLEN-1:0]   rt_val,
    input  logic                          wb_we,
    input  logic [tinker_pkg::REG_AW-1:0] wb_rd,
    input  logic [tinker_pkg::XLEN-1:0]   wb_data
);
    localparam int NREGS = 2 ** tinker_pkg::REG_AW;

    logic [tinker_pkg::XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++)
                regs[i] <= (i == NREGS - 1) ? STACK_TOP : '0;  // r31 is the stack pointer
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-through, ID sees the value WB writes this cycle
    always_comb begin
        rd_val = (wb_we && wb_rd == rd) ? wb_data : regs[rd];
        rs_val = (wb_we && wb_rd == rs) ? wb_data : regs[rs];
        rt_val = (wb_we && wb_rd == rt) ? wb_data : regs[rt];
    end

endmodule

//--- source/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode #(
    parameter logic [tinker_pkg::ADDR_W-1:0] PC_RESET_ADDR = 32'h2000
) (
    input  logic                           clk,
    input  logic                           reset,
    output logic [tinker_pkg::ADDR_W-1:0]  fetch_addr,
    input  logic [tinker_pkg::INSTR_W-1:0] fetch_instr,
    output logic [tinker_pkg::REG_AW-1:0]  rd,
    output logic [tinker_pkg::REG_AW-1:0]  rs,
    output logic [tinker_pkg::REG_AW-1:0]  rt,
    input  logic [tinker_pkg::XLEN-1:0]    rd_val,
    input  logic [tinker_pkg::XLEN-1:0]    rs_val,
    input  logic [tinker_pkg::XLEN-1:0]    rt_val,
    output tinker_pkg::opcode_t            id_op,
    output logic                           id_reg_write,
    output logic                           id_mem_read,
    output logic                           id_mem_write,
    output logic                           id_halt,
    output logic [tinker_pkg::REG_AW-1:0]  id_rd,
    output logic [tinker_pkg::REG_AW-1:0]  id_rs,
    output logic [tinker_pkg::REG_AW-1:0]  id_rt,
    output logic [tinker_pkg::LIT_W-1:0]   id_lit,
    output logic [tinker_pkg::XLEN-1:0]    id_rd_val,
    output logic [tinker_pkg::XLEN-1:0]    id_rs_val,
    output logic [tinker_pkg::XLEN-1:0]    id_rt_val
);
    logic [tinker_pkg::ADDR_W-1:0]  pc;
    logic [tinker_pkg::INSTR_W-1:0] ifid_instr;
    tinker_pkg::opcode_t            op;
    logic [tinker_pkg::LIT_W-1:0]   lit;
    logic                           reg_write, mem_read, mem_write, halt;
    logic                           stall;

    assign fetch_addr = pc;  // fetch word comes back this cycle

    // pc and IF/ID both freeze on a stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= PC_RESET_ADDR;
            ifid_instr <= tinker_pkg::NOP_INSTR;
        end else if (!stall) begin
            pc         <= pc + tinker_pkg::PC_STEP;
            ifid_instr <= fetch_instr;
        end
    end

    // field split
    assign op  = tinker_pkg::opcode_t'(ifid_instr[tinker_pkg::OP_LSB +: $bits(op)]);
    assign rd  = ifid_instr[tinker_pkg::RD_LSB +: tinker_pkg::REG_AW];
    assign rs  = ifid_instr[tinker_pkg::RS_LSB +: tinker_pkg::REG_AW];
    assign rt  = ifid_instr[tinker_pkg::RT_LSB +: tinker_pkg::REG_AW];
    assign lit = ifid_instr[tinker_pkg::LIT_W-1:0];

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        halt      = 1'b0;
        case (op)
            tinker_pkg::OP_AND, tinker_pkg::OP_OR, tinker_pkg::OP_XOR, tinker_pkg::OP_NOT,
            tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTRI, tinker_pkg::OP_SHFTL,
            tinker_pkg::OP_SHFTLI, tinker_pkg::OP_MOV, tinker_pkg::OP_MOVL,
            tinker_pkg::OP_ADD, tinker_pkg::OP_ADDI, tinker_pkg::OP_SUB,
            tinker_pkg::OP_SUBI: reg_write = 1'b1;
            tinker_pkg::OP_LOAD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            tinker_pkg::OP_STORE: mem_write = 1'b1;
            tinker_pkg::OP_HALT:  halt      = 1'b1;
            default: ;  // unknown opcode acts as a nop
        endcase
        if (rd == '0)
            reg_write = 1'b0;  // r0 writes dropped, nop makes no commit
    end

    // load in EX feeding any field of the instruction in ID
    assign stall = id_mem_read && (id_rd != '0)
                   && (id_rd == rd || id_rd == rs || id_rd == rt);

    // ID/EX, a stall clears the control bits so the load moves on alone
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_op        <= tinker_pkg::OP_AND;
            id_reg_write <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_halt      <= 1'b0;
            id_rd        <= '0;
            id_rs        <= '0;
            id_rt        <= '0;
            id_lit       <= '0;
            id_rd_val    <= '0;
            id_rs_val    <= '0;
            id_rt_val    <= '0;
        end else begin
            id_op        <= op;
            id_reg_write <= reg_write && !stall;
            id_mem_read  <= mem_read && !stall;
            id_mem_write <= mem_write && !stall;
            id_halt      <= halt && !stall;
            id_rd        <= stall ? '0 : rd;  // bubble has no destination
            id_rs        <= rs;
            id_rt        <= rt;
            id_lit       <= lit;
            id_rd_val    <= rd_val;
            id_rs_val    <= rs_val;
            id_rt_val    <= rt_val;
        end
    end

endmodule

//--- source/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                          clk,
    input  logic                          reset,
    input  tinker_pkg::opcode_t           id_op,
    input  logic                          id_reg_write,
    input  logic                          id_mem_read,
    input  logic                          id_mem_write,
    input  logic                          id_halt,
    input  logic [tinker_pkg::REG_AW-1:0] id_rd,
    input  logic [tinker_pkg::REG_AW-1:0] id_rs,
    input  logic [tinker_pkg::REG_AW-1:0] id_rt,
    input  logic [tinker_pkg::LIT_W-1:0]  id_lit,
    input  logic [tinker_pkg::XLEN-1:0]   id_rd_val,
    input  logic [tinker_pkg::XLEN-1:0]   id_rs_val,
    input  logic [tinker_pkg::XLEN-1:0]   id_rt_val,
    input  logic                          wb_we,
    input  logic [tinker_pkg::REG_AW-1:0] wb_rd,
    input  logic [tinker_pkg::XLEN-1:0]   wb_data,
    output logic                          ex_mem_read,     // EX/MEM load flag
    output logic [tinker_pkg::REG_AW-1:0] ex_rd,           // EX/MEM destination
    output logic                          mem_reg_write,
    output logic                          mem_mem_write,
    output logic                          mem_halt,
    output logic [tinker_pkg::XLEN-1:0]   mem_result,      // alu value or byte address
    output logic [tinker_pkg::XLEN-1:0]   mem_store_data
);
    localparam int XLEN = tinker_pkg::XLEN;

    logic [tinker_pkg::REG_AW-1:0] src_reg [3];  // 0 rd, 1 rs, 2 rt
    logic [XLEN-1:0]               src_val [3];
    logic [XLEN-1:0]               opnd    [3];
    tinker_pkg::fwd_sel_t          sel     [3];
    logic [XLEN-1:0]               lit_z, alu_out;

    assign src_reg = '{id_rd, id_rs, id_rt};
    assign src_val = '{id_rd_val, id_rs_val, id_rt_val};

    // EX/MEM first, then MEM/WB, r0 never forwards
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (mem_reg_write && ex_rd != '0 && ex_rd == src_reg[i])
                sel[i] = tinker_pkg::FWD_EXMEM;
            else if (wb_we && wb_rd != '0 && wb_rd == src_reg[i])
                sel[i] = tinker_pkg::FWD_MEMWB;
            else
                sel[i] = tinker_pkg::FWD_REG;
            case (sel[i])
                tinker_pkg::FWD_EXMEM: opnd[i] = mem_result;
                tinker_pkg::FWD_MEMWB: opnd[i] = wb_data;
                default:               opnd[i] = src_val[i];
            endcase
        end
    end

    assign lit_z = {{(XLEN - tinker_pkg::LIT_W){1'b0}}, id_lit};  // zero extended

    always_comb begin
        case (id_op)
            tinker_pkg::OP_ADD:    alu_out = opnd[1] + opnd[2];
            tinker_pkg::OP_ADDI:   alu_out = opnd[0] + lit_z;
            tinker_pkg::OP_SUB:    alu_out = opnd[1] - opnd[2];
            tinker_pkg::OP_SUBI:   alu_out = opnd[0] - lit_z;
            tinker_pkg::OP_AND:    alu_out = opnd[1] & opnd[2];
            tinker_pkg::OP_OR:     alu_out = opnd[1] | opnd[2];
            tinker_pkg::OP_XOR:    alu_out = opnd[1] ^ opnd[2];
            tinker_pkg::OP_NOT:    alu_out = ~opnd[1];
            tinker_pkg::OP_SHFTR:  alu_out = opnd[1] >> opnd[2];  // whole rt as amount
            tinker_pkg::OP_SHFTRI: alu_out = opnd[0] >> lit_z;
            tinker_pkg::OP_SHFTL:  alu_out = opnd[1] << opnd[2];
            tinker_pkg::OP_SHFTLI: alu_out = opnd[0] << lit_z;
            tinker_pkg::OP_MOV:    alu_out = opnd[1];
            tinker_pkg::OP_MOVL:   alu_out = {opnd[0][XLEN-1:tinker_pkg::LIT_W], id_lit};
            tinker_pkg::OP_LOAD:   alu_out = opnd[1] + lit_z;  // rs+L
            tinker_pkg::OP_STORE:  alu_out = opnd[0] + lit_z;  // rd+L
            default:               alu_out = '0;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem_read    <= 1'b0;
            ex_rd          <= '0;
            mem_reg_write  <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_halt       <= 1'b0;
            mem_result     <= '0;
            mem_store_data <= '0;
        end else begin
            ex_mem_read    <= id_mem_read;
            ex_rd          <= id_rd;
            mem_reg_write  <= id_reg_write;
            mem_mem_write  <= id_mem_write;
            mem_halt       <= id_halt;
            mem_result     <= alu_out;
            mem_store_data <= opnd[1];  // store writes rs
        end
    end

endmodule

//--- source/mem_writeback.sv
`timescale 1ns/1ps

module mem_writeback (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ex_mem_read,
    input  logic [tinker_pkg::REG_AW-1:0] ex_rd,
    input  logic                          mem_reg_write,
    input  logic                          mem_halt,
    input  logic [tinker_pkg::XLEN-1:0]   mem_result,
    input  logic [tinker_pkg::XLEN-1:0]   data_rdata,  // combinational load data
    output logic                          wb_we,
    output logic [tinker_pkg::REG_AW-1:0] wb_rd,
    output logic [tinker_pkg::XLEN-1:0]   wb_data,
    output logic                          hlt
);

    // MEM/WB, the load data is picked here so WB needs no mux
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_we   <= 1'b0;
            wb_rd   <= '0;
            wb_data <= '0;
            hlt     <= 1'b0;
        end else begin
            wb_we   <= mem_reg_write;
            wb_rd   <= ex_rd;
            wb_data <= ex_mem_read ? data_rdata : mem_result;
            hlt     <= mem_halt;  // high while halt sits in MEM/WB
        end
    end

endmodule

//--- source/tinker_top.sv
`timescale 1ns/1ps

module tinker_top #(
    parameter int                            MEM_BYTES     = 512 * 1024,
    parameter logic [tinker_pkg::ADDR_W-1:0] PC_RESET_ADDR = 32'h2000,
    parameter logic [tinker_pkg::XLEN-1:0]   STACK_TOP     = 64'h8_0000
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           prog_we,
    input  logic [tinker_pkg::ADDR_W-1:0]  prog_addr,
    input  logic [tinker_pkg::INSTR_W-1:0] prog_data,
    output logic                           hlt,
    output logic                           commit_we,    // the WB write itself
    output logic [tinker_pkg::REG_AW-1:0]  commit_rd,
    output logic [tinker_pkg::XLEN-1:0]    commit_data
);
    logic [tinker_pkg::ADDR_W-1:0]  fetch_addr;
    logic [tinker_pkg::INSTR_W-1:0] fetch_instr;
    logic [tinker_pkg::REG_AW-1:0]  rd, rs, rt;
    logic [tinker_pkg::XLEN-1:0]    rd_val, rs_val, rt_val;
    tinker_pkg::opcode_t            id_op;
    logic                           id_reg_write, id_mem_read, id_mem_write, id_halt;
    logic [tinker_pkg::REG_AW-1:0]  id_rd, id_rs, id_rt;
    logic [tinker_pkg::LIT_W-1:0]   id_lit;
    logic [tinker_pkg::XLEN-1:0]    id_rd_val, id_rs_val, id_rt_val;
    logic                           ex_mem_read, mem_reg_write, mem_mem_write, mem_halt;
    logic [tinker_pkg::REG_AW-1:0]  ex_rd;
    logic [tinker_pkg::XLEN-1:0]    mem_result, mem_store_data, data_rdata;

    unified_memory #(.MEM_BYTES(MEM_BYTES)) u_mem (
        .clk, .prog_we, .prog_addr, .prog_data, .fetch_addr, .fetch_instr,
        .data_addr (mem_result[tinker_pkg::ADDR_W-1:0]),
        .data_rdata,
        .store_we  (mem_mem_write),
        .store_data(mem_store_data)
    );

    // commit port doubles as the writeback bus
    reg_file #(.STACK_TOP(STACK_TOP)) u_regs (
        .clk, .reset, .rd, .rs, .rt, .rd_val, .rs_val, .rt_val,
        .wb_we(commit_we), .wb_rd(commit_rd), .wb_data(commit_data)
    );

    fetch_decode #(.PC_RESET_ADDR(PC_RESET_ADDR)) u_fd (
        .clk, .reset, .fetch_addr, .fetch_instr, .rd, .rs, .rt, .rd_val, .rs_val, .rt_val,
        .id_op, .id_reg_write, .id_mem_read, .id_mem_write, .id_halt,
        .id_rd, .id_rs, .id_rt, .id_lit, .id_rd_val, .id_rs_val, .id_rt_val
    );

    execute u_ex (
        .clk, .reset, .id_op, .id_reg_write, .id_mem_read, .id_mem_write, .id_halt,
        .id_rd, .id_rs, .id_rt, .id_lit, .id_rd_val, .id_rs_val, .id_rt_val,
        .wb_we(commit_we), .wb_rd(commit_rd), .wb_data(commit_data),
        .ex_mem_read, .ex_rd, .mem_reg_write, .mem_mem_write, .mem_halt,
        .mem_result, .mem_store_data
    );

    mem_writeback u_wb (
        .clk, .reset, .ex_mem_read, .ex_rd, .mem_reg_write, .mem_halt, .mem_result,
        .data_rdata, .wb_we(commit_we), .wb_rd(commit_rd), .wb_data(commit_data), .hlt
    );

endmodule

//--- bench/tinker_asserts.sv
`timescale 1ns/1ps

module tinker_asserts (
    input logic                           clk,
    input logic                           reset,
    input logic                           stall,
    input logic [tinker_pkg::ADDR_W-1:0]  pc,
    input logic [tinker_pkg::INSTR_W-1:0] ifid_instr
);

    // the bubble pulls the load out of ID/EX, so a second stall cycle is a bug
    single_cycle_stall: assert property (@(posedge clk) disable iff (reset)
        stall |=> !stall)
        else $error("load-use stall lasted two cycles");

    pc_holds_on_stall: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(pc))
        else $error("pc moved during a load-use stall");

    ifid_holds_on_stall: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(ifid_instr))  // instruction in ID waits
        else $error("IF/ID changed during a load-use stall");

endmodule

bind fetch_decode tinker_asserts u_asserts (
    .clk(clk), .reset(reset), .stall(stall),
    .pc(pc), .ifid_instr(ifid_instr)
);

//--- bench/tinker_tb.sv
`timescale 1ns/1ps

module tinker_tb;
    localparam logic [31:0] PC_RESET_ADDR  = 32'h2000;
    localparam logic [63:0] STACK_TOP      = 64'h8_0000;
    localparam int          NROWS          = 36;
    localparam int          HALT_PAD       = 4;  // halts behind the last row fill the pipe
    localparam int          TIMEOUT_CYCLES = NROWS * 10 + 100;

    logic        clk = 1'b0;
    logic        reset, prog_we;
    logic [31:0] prog_addr, prog_data;
    logic        hlt, commit_we;
    logic [4:0]  commit_rd;
    logic [63:0] commit_data;

    // the table, one row per instruction
    int          row_num [NROWS];
    logic [31:0] row_word [NROWS];
    bit          row_we [NROWS];  // commit expected
    logic [4:0]  row_rd [NROWS];
    logic [63:0] row_val [NROWS];

    int errors = 0;
    int tests_failed = 0;
    int idx = 0;      // next row to retire
    int ncommit = 0;
    int nexp = 0;     // rows that expect a commit

    tinker_top #(
        .PC_RESET_ADDR(PC_RESET_ADDR), .STACK_TOP(STACK_TOP)
    ) u_dut (
        .clk, .reset, .prog_we, .prog_addr, .prog_data,
        .hlt, .commit_we, .commit_rd, .commit_data
    );

    always #5 clk = ~clk;  // 10 ns period

    function automatic logic [31:0] enc(input logic [4:0] op, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [11:0] lit);
        enc = {op, rd, rs, rt, lit};  // op 31..27, rd, rs, rt, literal 11..0
    endfunction

    task automatic add_row(input int num, input logic [31:0] word, input bit we,
                           input logic [4:0] rd, input logic [63:0] val);
        row_num[num-1]  = num;
        row_word[num-1] = word;
        row_we[num-1]   = we;
        row_rd[num-1]   = rd;
        row_val[num-1]  = val;
        if (we)
            nexp++;
    endtask

    task automatic build_table();
        add_row(1, enc(tinker_pkg::OP_MOVL, 1, 0, 0, 12'h123), 1, 1, 64'h123);
        add_row(2, enc(tinker_pkg::OP_MOVL, 2, 0, 0, 12'h0F0), 1, 2, 64'hF0);
        add_row(3, enc(tinker_pkg::OP_ADD, 3, 1, 2, 0), 1, 3, 64'h213);     // rt dist 1, rs dist 2
        add_row(4, enc(tinker_pkg::OP_SUB, 4, 3, 2, 0), 1, 4, 64'h123);     // rs dist 1
        add_row(5, enc(tinker_pkg::OP_AND, 5, 1, 2, 0), 1, 5, 64'h20);      // rt dist 3
        add_row(6, enc(tinker_pkg::OP_OR, 6, 1, 2, 0), 1, 6, 64'h1F3);
        add_row(7, enc(tinker_pkg::OP_XOR, 7, 1, 2, 0), 1, 7, 64'h1D3);
        add_row(8, enc(tinker_pkg::OP_NOT, 8, 1, 0, 0), 1, 8, 64'hFFFF_FFFF_FFFF_FEDC);
        add_row(9, enc(tinker_pkg::OP_ADDI, 1, 0, 0, 12'h00F), 1, 1, 64'h132);
        add_row(10, enc(tinker_pkg::OP_SUBI, 1, 0, 0, 12'h002), 1, 1, 64'h130);  // rd dist 1
        add_row(11, enc(tinker_pkg::OP_SHFTRI, 1, 0, 0, 12'd4), 1, 1, 64'h13);
        add_row(12, enc(tinker_pkg::OP_SHFTLI, 1, 0, 0, 12'd8), 1, 1, 64'h1300);
        add_row(13, enc(tinker_pkg::OP_MOVL, 9, 0, 0, 12'd4), 1, 9, 64'h4);
        add_row(14, enc(tinker_pkg::OP_SHFTR, 10, 2, 9, 0), 1, 10, 64'hF);
        add_row(15, enc(tinker_pkg::OP_SHFTL, 11, 2, 9, 0), 1, 11, 64'hF00);   // rt dist 2
        add_row(16, enc(tinker_pkg::OP_MOV, 12, 31, 0, 0), 1, 12, STACK_TOP);  // r31 after reset
        add_row(17, enc(tinker_pkg::OP_ADD, 13, 31, 9, 0), 1, 13, STACK_TOP + 4);
        add_row(18, enc(tinker_pkg::OP_MOVL, 13, 0, 0, 12'hABC), 1, 13, 64'h8_0ABC);
        add_row(19, enc(tinker_pkg::OP_MOV, 14, 13, 0, 0), 1, 14, 64'h8_0ABC);
        add_row(20, enc(tinker_pkg::OP_MOVL, 15, 0, 0, 12'h010), 1, 15, 64'h10);
        add_row(21, enc(tinker_pkg::OP_MOVL, 16, 0, 0, 12'h020), 1, 16, 64'h20);
        add_row(22, enc(tinker_pkg::OP_ADDI, 15, 0, 0, 12'h001), 1, 15, 64'h11);  // rd dist 2
        add_row(23, enc(tinker_pkg::OP_MOVL, 17, 0, 0, 12'd5), 1, 17, 64'h5);
        add_row(24, enc(tinker_pkg::OP_MOVL, 18, 0, 0, 12'd6), 1, 18, 64'h6);
        add_row(25, enc(tinker_pkg::OP_MOVL, 19, 0, 0, 12'd7), 1, 19, 64'h7);
        add_row(26, enc(tinker_pkg::OP_ADDI, 17, 0, 0, 12'h010), 1, 17, 64'h15);  // rd dist 3
        add_row(27, enc(tinker_pkg::OP_ADD, 20, 18, 19, 0), 1, 20, 64'hD);  // rs dist 3
        add_row(28, enc(tinker_pkg::OP_MOVL, 21, 0, 0, 12'h400), 1, 21, 64'h400);  // data base
        add_row(29, enc(tinker_pkg::OP_STORE, 21, 8, 0, 12'h008), 0, 0, 0);
        add_row(30, enc(tinker_pkg::OP_LOAD, 22, 21, 0, 12'h008), 1, 22, 64'hFFFF_FFFF_FFFF_FEDC);
        add_row(31, enc(tinker_pkg::OP_ADD, 23, 22, 1, 0), 1, 23, 64'h11DC);  // load-use on rs
        add_row(32, enc(tinker_pkg::OP_STORE, 21, 23, 0, 12'h010), 0, 0, 0);
        add_row(33, enc(tinker_pkg::OP_LOAD, 24, 21, 0, 12'h010), 1, 24, 64'h11DC);
        add_row(34, enc(tinker_pkg::OP_MOVL, 24, 0, 0, 12'h0FF), 1, 24, 64'h10FF);  // on rd
        add_row(35, enc(tinker_pkg::OP_LOAD, 25, 21, 0, 12'h008), 1, 25, 64'hFFFF_FFFF_FFFF_FEDC);
        add_row(36, enc(tinker_pkg::OP_SUB, 26, 1, 25, 0), 1, 26, 64'h1424);  // load-use on rt
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_row(input int r, input bit bad);
        $display("test %0d: %s", row_num[r], bad ? "FAIL" : "ok");
        if (bad)
            tests_failed++;
    endtask

    // stores make no commit, retire them as they are passed
    task automatic retire_silent_rows();
        while (idx < NROWS && !row_we[idx]) begin
            report_row(idx, 1'b0);
            idx++;
        end
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: no halt after %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int  errs_before;
        bit  done;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        done      = 1'b0;
        build_table();

        // program goes in while the core sits in reset
        for (int i = 0; i < NROWS + HALT_PAD; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= PC_RESET_ADDR + 32'(4 * i);
            prog_data <= (i < NROWS) ? row_word[i] : enc(tinker_pkg::OP_HALT, 0, 0, 0, 0);
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("commit_we", 64'(commit_we), 0);  // quiet ports out of reset
        check("hlt", 64'(hlt), 0);
        @(posedge clk);
        reset <= 1'b0;

        // outputs are registered, sample mid-cycle
        while (!done) begin
            @(negedge clk);
            if (commit_we) begin
                retire_silent_rows();
                if (idx >= NROWS) begin
                    $display("unexpected commit to r%0d after the last test", commit_rd);
                    errors++;
                end else begin
                    errs_before = errors;
                    check("commit_rd", 64'(commit_rd), 64'(row_rd[idx]));
                    check("commit_data", commit_data, row_val[idx]);
                    report_row(idx, errors != errs_before);
                    idx++;
                end
                ncommit++;
            end
            if (hlt)
                done = 1'b1;
        end
        retire_silent_rows();
        check("commit count", 64'(ncommit), 64'(nexp));  // hlt came after the last commit

        $display("summary: %0d tests, %0d failed, %0d commits, %0d errors",
                 NROWS, tests_failed, ncommit, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
source/tinker_pkg.sv
source/unified_memory.sv
source/reg_file.sv
source/fetch_decode.sv
source/execute.sv
source/mem_writeback.sv
source/tinker_top.sv
bench/tinker_asserts.sv
bench/tinker_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tinker core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tinker_tb -f project.f -Mdir obj_dir -o tinker_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tinker_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
exit 1
